// ==== list.f ====
+incdir+common
common/dma_pkg.sv
common/mem_port_if.sv
hermes/hermes_receiver.sv
hermes/hermes_sender.sv
design/mem_arbiter.sv
design/dma_top.sv
bench/mem_model.sv
bench/tb_dma.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the DMA testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f list.f --top-module tb_dma -o tb_dma

output=$(./obj_dir/tb_dma)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qxF '>>> PASS'; then
    exit 0
else
    exit 1
fi

// ==== bench/tb_dma.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dma_config.svh"

module tb_dma;

    import dma_pkg::*;

    localparam int TIMEOUT   = 1000;
    localparam int NUM_CASES = 7;
    localparam logic [31:0] FILL_KEY = 32'h5A5A_0000;

    typedef struct {
        int          kind;       // 0 receive, 1 send, 2 both
        int          pkt_len;
        int          split;      // Words in the first receive operation
        logic [31:0] rx_addr;
        logic [31:0] rx_addr_2;
        logic [31:0] rx_first;   // Payload flit 0, then counting up
        logic [31:0] tx_addr;
        int          tx_size;
        logic [31:0] tx_first;
        logic [31:0] tx_addr_2;
        int          tx_size_2;
        logic [31:0] tx_first_2;
        int          gap_pct;    // Chance of an idle rx or ack cycle
    } case_t;

    logic        clk;
    logic        rst_n;
    logic        noc_rx;
    logic        noc_credit;
    logic [31:0] noc_data_in;
    logic        noc_tx;
    logic        noc_ack;
    logic [31:0] noc_data_out;
    logic [3:0]  mem_we;
    logic [31:0] mem_addr;
    logic [31:0] mem_rdata;
    logic [31:0] mem_wdata;
    logic        start;
    dma_op_t     operation;
    logic [31:0] size;
    logic [31:0] size_2;
    logic [31:0] address;
    logic [31:0] address_2;
    logic        send_active;
    logic        receive_active;
    logic        receive_available;
    logic [31:0] flits_available;

    case_t       cases [NUM_CASES];
    logic [31:0] tx_words [$];
    int          errors;
    int          checks;
    int          ci;
    logic        timed_out;

    dma_top uut (
        .clk_i (clk), .rst_ni (rst_n),
        .noc_rx_i (noc_rx), .noc_credit_o (noc_credit), .noc_data_i (noc_data_in),
        .noc_tx_o (noc_tx), .noc_ack_i (noc_ack), .noc_data_o (noc_data_out),
        .mem_we_o (mem_we), .mem_addr_o (mem_addr),
        .mem_data_i (mem_rdata), .mem_data_o (mem_wdata),
        .start_i (start), .operation_i (operation),
        .size_i (size), .size_2_i (size_2), .address_i (address), .address_2_i (address_2),
        .send_active_o (send_active), .receive_active_o (receive_active),
        .receive_available_o (receive_available), .flits_available_o (flits_available)
    );

    mem_model u_mem (
        .clk_i (clk), .we_i (mem_we), .addr_i (mem_addr), .data_i (mem_wdata), .data_o (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic report_timeout(input string what);
        timed_out = 1'b1;
        errors++;
        $display("Timeout at %0d ns while waiting for %s", $time, what);
    endtask

    function automatic logic idle_cycle(input int pct);
        return $urandom_range(99) < pct;
    endfunction

    function automatic logic status(input int sel);
        case (sel)
            0:       return receive_available;
            1:       return receive_active;
            default: return send_active;
        endcase
    endfunction

    task automatic wait_status(input int sel, input logic level, input string what);
        int n;
        n = 0;
        while (status(sel) !== level && !timed_out) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT)
                report_timeout(what);
        end
    endtask

    task automatic pulse_start(input dma_op_t op, input logic [31:0] addr, input int len,
                               input logic [31:0] addr_2, input int len_2);
        @(negedge clk);
        start     = 1'b1;
        operation = op;
        address   = addr;
        size      = len;
        address_2 = addr_2;
        size_2    = len_2;
        @(negedge clk);
        start = 1'b0;
    endtask

    // Header, size, then payload; a flit moves on when credit is seen
    task automatic feed_packet(input case_t c);
        int idx;
        int stall;
        idx = 0;
        stall = 0;
        while (idx < c.pkt_len + 2 && !timed_out) begin
            @(negedge clk);
            noc_rx = !idle_cycle(c.gap_pct);
            if (idx == 0)
                noc_data_in = 32'h0000_0101;
            else if (idx == 1)
                noc_data_in = 32'(c.pkt_len);
            else
                noc_data_in = c.rx_first + 32'(idx - 2);
            #1;
            if (noc_rx && noc_credit) begin
                idx++;
                stall = 0;
            end else begin
                stall++;
                if (stall > TIMEOUT)
                    report_timeout("flit acceptance");
            end
        end
        @(negedge clk);
        noc_rx = 1'b0;
    endtask

    task automatic control_receive(input case_t c);
        int op;
        int len;
        for (op = 0; op < 2 && !timed_out; op++) begin
            len = (op == 0) ? c.split : c.pkt_len - c.split;
            if (len > 0) begin
                wait_status(0, 1'b1, "receive_available_o");
                check(flits_available, 32'(c.pkt_len - op * c.split), "flits_available_o");
                pulse_start(DMA_OP_RECEIVE, (op == 0) ? c.rx_addr : c.rx_addr_2, len, '0, 0);
            end
        end
    endtask

    task automatic collect_send(input case_t c);
        int n;
        int idle;
        n = 0;
        idle = 0;
        while (idle < 3 && !timed_out) begin  // A few quiet cycles catch extra strobes
            @(negedge clk);
            if (noc_tx)
                tx_words.push_back(noc_data_out);
            noc_ack = !idle_cycle(c.gap_pct);
            idle = send_active ? 0 : idle + 1;
            n++;
            if (n > TIMEOUT)
                report_timeout("end of send");
        end
        noc_ack = 1'b1;
    endtask

    task automatic run_case(input int num, input case_t c);
        int          err_before;
        int          k;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] expected;
        err_before = errors;
        tx_words.delete();
        u_mem.fill(FILL_KEY);
        u_mem.preload(c.tx_addr, c.tx_size, c.tx_first);
        u_mem.preload(c.tx_addr_2, c.tx_size_2, c.tx_first_2);
        if (c.kind != 0)
            pulse_start(DMA_OP_SEND, c.tx_addr, c.tx_size, c.tx_addr_2, c.tx_size_2);
        fork
            if (c.kind != 1) feed_packet(c);
            if (c.kind != 1) control_receive(c);
            if (c.kind != 0) collect_send(c);
        join
        wait_status(1, 1'b0, "receive_active_o low");
        wait_status(2, 1'b0, "send_active_o low");
        if (c.kind != 1) begin
            for (k = 0; k < c.pkt_len; k++) begin
                if (k < c.split)
                    addr = c.rx_addr + `DMA_ADDR_STEP * k;
                else
                    addr = c.rx_addr_2 + `DMA_ADDR_STEP * (k - c.split);
                u_mem.peek(addr, data);
                check(data, c.rx_first + 32'(k), $sformatf("received word %0d", k));
            end
            addr = c.rx_addr + `DMA_ADDR_STEP * c.split;
            u_mem.peek(addr, data);
            check(data, addr ^ FILL_KEY, "word past first region");
            check(32'(noc_credit), 32'd1, "noc_credit_o back in header state");
            check(32'(receive_available), 32'd0, "receive_available_o after packet");
        end
        if (c.kind != 0) begin
            check(tx_words.size(), 32'(c.tx_size + c.tx_size_2), "send word count");
            foreach (tx_words[i]) begin
                if (i < c.tx_size)
                    expected = c.tx_first + 32'(i);
                else
                    expected = c.tx_first_2 + 32'(i - c.tx_size);
                check(tx_words[i], expected, $sformatf("send word %0d", i));
            end
        end
        $display("Case %0d kind %0d finished with %0d errors", num, c.kind, errors - err_before);
    endtask

    initial begin
        void'($urandom(32'h0bd84ad1));
        errors = 0;
        checks = 0;
        timed_out = 1'b0;
        rst_n = 1'b0;
        noc_rx = 1'b0;
        noc_data_in = '0;
        noc_ack = 1'b1;
        start = 1'b0;
        operation = DMA_OP_SEND;
        size = '0;
        size_2 = '0;
        address = '0;
        address_2 = '0;
        cases[0] = '{0, 6, 6, 32'h100, 32'h0, 32'hA000_0000, 32'h0, 0, 32'h0, 32'h0, 0, 32'h0, 0};
        cases[1] = '{0, 8, 3, 32'h200, 32'h300, 32'hA100_0000, 32'h0, 0, 32'h0, 32'h0, 0, 32'h0, 0};
        cases[2] = '{1, 0, 0, 32'h0, 32'h0, 32'h0, 32'h400, 5, 32'hB000_0000,
                     32'h500, 4, 32'hB100_0000, 0};
        cases[3] = '{1, 0, 0, 32'h0, 32'h0, 32'h0, 32'h600, 7, 32'hB200_0000,
                     32'h700, 6, 32'hB300_0000, 40};
        cases[4] = '{0, 9, 9, 32'h800, 32'h0, 32'hA200_0000, 32'h0, 0, 32'h0, 32'h0, 0, 32'h0, 40};
        cases[5] = '{2, 10, 4, 32'h900, 32'hA00, 32'hA300_0000, 32'hB00, 6, 32'hB400_0000,
                     32'hC00, 5, 32'hB500_0000, 25};
        cases[6] = '{1, 0, 0, 32'h0, 32'h0, 32'h0, 32'h0, 0, 32'h0,
                     32'hD00, 3, 32'hB600_0000, 0};  // Buffer one empty
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check(32'(noc_tx), 32'd0, "noc_tx_o after reset");
        check(32'(mem_we), 32'd0, "mem_we_o after reset");
        check(32'(send_active), 32'd0, "send_active_o after reset");
        check(32'(receive_active), 32'd0, "receive_active_o after reset");
        check(32'(receive_available), 32'd0, "receive_available_o after reset");
        check(32'(noc_credit), 32'd1, "noc_credit_o after reset");
        $display("Reset values finished with %0d errors", errors);
        for (ci = 0; ci < NUM_CASES && !timed_out; ci++)
            run_case(ci, cases[ci]);
        $display("Done: %0d cases, %0d checks, %0d errors", ci, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dma_config.svh"

module mem_model #(
    parameter int WORDS = 1024
) (
    input  wire logic                    clk_i,
    input  wire logic [3:0]              we_i,
    input  wire logic [31:0]             addr_i,
    input  wire logic [`DMA_FLIT_W-1:0]  data_i,
    output logic [`DMA_FLIT_W-1:0]       data_o
);

    localparam int AW = $clog2(WORDS);

    logic [`DMA_FLIT_W-1:0] mem [WORDS];
    logic [AW-1:0]          index;

    assign index = addr_i[AW+1:2];  // Byte address to word index

    always @(posedge clk_i) begin
        if (we_i[0]) mem[index][7:0]   <= data_i[7:0];
        if (we_i[1]) mem[index][15:8]  <= data_i[15:8];
        if (we_i[2]) mem[index][23:16] <= data_i[23:16];
        if (we_i[3]) mem[index][31:24] <= data_i[31:24];
        data_o <= mem[index];  // One cycle read latency
    end

    // Every word gets its own byte address mixed with a key
    task automatic fill(input logic [31:0] key);
        logic [AW-1:0] idx;
        idx = '0;
        repeat (WORDS) begin
            mem[idx] <= 32'({idx, 2'b00}) ^ key;
            idx = idx + AW'(1);
        end
    endtask

    task automatic preload(input logic [31:0] addr, input int count, input logic [31:0] first);
        logic [AW-1:0] idx;
        logic [31:0]   value;
        idx = addr[AW+1:2];
        value = first;
        repeat (count) begin
            mem[idx] <= value;
            idx = idx + AW'(1);
            value = value + 32'd1;
        end
    endtask

    task automatic peek(input logic [31:0] addr, output logic [`DMA_FLIT_W-1:0] data);
        data = mem[addr[AW+1:2]];
    endtask

endmodule

`default_nettype wire

// ==== design/dma_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dma_config.svh"

module dma_top (
    input  wire logic                      clk_i,
    input  wire logic                      rst_ni,

    // Hermes receive side
    input  wire logic                      noc_rx_i,
    output logic                           noc_credit_o,
    input  wire logic [`DMA_FLIT_W-1:0]    noc_data_i,

    // Hermes send side
    output logic                           noc_tx_o,
    input  wire logic                      noc_ack_i,
    output logic [`DMA_FLIT_W-1:0]         noc_data_o,

    // Memory
    output logic [3:0]                     mem_we_o,
    output logic [31:0]                    mem_addr_o,
    input  wire logic [`DMA_FLIT_W-1:0]    mem_data_i,
    output logic [`DMA_FLIT_W-1:0]         mem_data_o,

    // Configuration
    input  wire logic                      start_i,
    input  wire dma_pkg::dma_op_t          operation_i,
    input  wire logic [31:0]               size_i,
    input  wire logic [31:0]               size_2_i,
    input  wire logic [31:0]               address_i,
    input  wire logic [31:0]               address_2_i,
    output logic                           send_active_o,
    output logic                           receive_active_o,
    output logic                           receive_available_o,
    output logic [`DMA_FLIT_W-1:0]         flits_available_o
);

    mem_port_if send_port ();
    mem_port_if receive_port ();

    hermes_receiver u_receiver (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .noc_rx_i          (noc_rx_i),
        .noc_credit_o      (noc_credit_o),
        .noc_data_i        (noc_data_i),
        .start_i           (start_i),
        .operation_i       (operation_i),
        .address_i         (address_i),
        .size_i            (size_i),
        .mem               (receive_port.engine),
        .active_o          (receive_active_o),
        .available_o       (receive_available_o),
        .flits_available_o (flits_available_o)
    );

    hermes_sender u_sender (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .noc_ack_i   (noc_ack_i),
        .noc_tx_o    (noc_tx_o),
        .start_i     (start_i),
        .operation_i (operation_i),
        .address_i   (address_i),
        .size_i      (size_i),
        .address_2_i (address_2_i),
        .size_2_i    (size_2_i),
        .mem         (send_port.engine),
        .active_o    (send_active_o)
    );

    mem_arbiter u_arbiter (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .send       (send_port.arbiter),
        .receive    (receive_port.arbiter),
        .mem_we_o   (mem_we_o),
        .mem_addr_o (mem_addr_o),
        .mem_data_o (mem_data_o)
    );

    // Read data goes straight out, noc_tx_o marks it valid
    assign noc_data_o = mem_data_i;

endmodule

`default_nettype wire

// ==== design/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dma_config.svh"

module mem_arbiter (
    input  wire logic                clk_i,
    input  wire logic                rst_ni,

    mem_port_if.arbiter              send,
    mem_port_if.arbiter              receive,

    output logic [3:0]               mem_we_o,
    output logic [31:0]              mem_addr_o,
    output logic [`DMA_FLIT_W-1:0]   mem_data_o
);

    import dma_pkg::*;

    localparam int TIMER_W = $clog2(`DMA_SLICE_CYCLES + 1);

    dma_src_t           grant_q;
    dma_src_t           grant_d;
    logic [TIMER_W-1:0] timer_q;

    logic any_req;
    logic holder_req;
    logic other_req;
    logic move;

    assign any_req    = send.req || receive.req;
    assign holder_req = (grant_q == SRC_SEND) ? send.req : receive.req;
    assign other_req  = (grant_q == SRC_SEND) ? receive.req : send.req;

    // Two sources, so round robin means the other one when it asks
    always_comb begin
        grant_d = grant_q;
        if (other_req) begin
            case (grant_q)
                SRC_SEND:    grant_d = SRC_RECEIVE;
                SRC_RECEIVE: grant_d = SRC_SEND;
                default:     grant_d = SRC_SEND;
            endcase
        end
    end

    assign move = any_req && (timer_q == '0 || !holder_req);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            grant_q <= SRC_SEND;
            timer_q <= '0;
        end else if (move) begin
            grant_q <= grant_d;
            timer_q <= TIMER_W'(`DMA_SLICE_CYCLES);  // New slice
        end else if (timer_q != '0) begin
            timer_q <= timer_q - TIMER_W'(1);
        end
    end

    assign send.gnt    = (grant_q == SRC_SEND);
    assign receive.gnt = (grant_q == SRC_RECEIVE);

    // Memory port follows the current holder
    always_comb begin
        if (grant_q == SRC_RECEIVE) begin
            mem_addr_o = receive.addr;
            mem_data_o = receive.wdata;
            mem_we_o   = {4{receive.req && receive.we}};
        end else begin
            mem_addr_o = send.addr;
            mem_data_o = send.wdata;
            mem_we_o   = {4{send.req && send.we}};
        end
    end

endmodule

`default_nettype wire

// ==== hermes/hermes_sender.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dma_config.svh"

module hermes_sender (
    input  wire logic              clk_i,
    input  wire logic              rst_ni,

    input  wire logic              noc_ack_i,
    output logic                   noc_tx_o,

    input  wire logic              start_i,
    input  wire dma_pkg::dma_op_t  operation_i,
    input  wire logic [31:0]       address_i,
    input  wire logic [31:0]       size_i,
    input  wire logic [31:0]       address_2_i,
    input  wire logic [31:0]       size_2_i,

    mem_port_if.engine             mem,

    output logic                   active_o
);

    import dma_pkg::*;

    typedef enum logic [1:0] {
        TX_IDLE = 2'b01,
        TX_SEND = 2'b10
    } tx_state_t;

    tx_state_t state_q;

    logic [31:0] addr_q;
    logic [31:0] size_q;
    logic [31:0] addr_2_q;
    logic [31:0] size_2_q;

    logic tx_start;
    logic use_first;
    logic issue;
    logic last_read;

    assign tx_start  = start_i && (operation_i == DMA_OP_SEND) && ((size_i | size_2_i) != '0);
    assign use_first = (size_q != '0);  // Buffer one drains first
    assign issue     = (state_q == TX_SEND) && mem.gnt && noc_ack_i;
    assign last_read = issue && ((size_q == 32'd1 && size_2_q == '0)
                              || (size_q == '0 && size_2_q == 32'd1));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= TX_IDLE;
        end else begin
            case (state_q)
                TX_IDLE: if (tx_start) state_q <= TX_SEND;
                TX_SEND: if (last_read) state_q <= TX_IDLE;
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            addr_q   <= '0;
            size_q   <= '0;
            addr_2_q <= '0;
            size_2_q <= '0;
        end else if (state_q == TX_IDLE && tx_start) begin
            addr_q   <= address_i;
            size_q   <= size_i;
            addr_2_q <= address_2_i;
            size_2_q <= size_2_i;
        end else if (issue) begin
            if (use_first) begin
                addr_q <= addr_q + 32'(`DMA_ADDR_STEP);
                size_q <= size_q - 32'd1;
            end else begin
                addr_2_q <= addr_2_q + 32'(`DMA_ADDR_STEP);
                size_2_q <= size_2_q - 32'd1;
            end
        end
    end

    // Read data lands one cycle after the strobe
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni)
            noc_tx_o <= 1'b0;
        else
            noc_tx_o <= issue;
    end

    assign mem.req   = (state_q == TX_SEND);
    assign mem.we    = 1'b0;
    assign mem.addr  = use_first ? addr_q : addr_2_q;
    assign mem.wdata = '0;

    assign active_o = (state_q == TX_SEND);

endmodule

`default_nettype wire

// ==== hermes/hermes_receiver.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dma_config.svh"

module hermes_receiver (
    input  wire logic                      clk_i,
    input  wire logic                      rst_ni,

    input  wire logic                      noc_rx_i,
    output logic                           noc_credit_o,
    input  wire logic [`DMA_FLIT_W-1:0]    noc_data_i,

    input  wire logic                      start_i,
    input  wire dma_pkg::dma_op_t          operation_i,
    input  wire logic [31:0]               address_i,
    input  wire logic [31:0]               size_i,

    mem_port_if.engine                     mem,

    output logic                           active_o,
    output logic                           available_o,
    output logic [`DMA_FLIT_W-1:0]         flits_available_o
);

    import dma_pkg::*;

    typedef enum logic [3:0] {
        RX_HEADER = 4'b0001,
        RX_SIZE   = 4'b0010,
        RX_WAIT   = 4'b0100,
        RX_DATA   = 4'b1000
    } rx_state_t;

    rx_state_t state_q;
    rx_state_t state_d;

    logic [31:0]            addr_q;
    logic [31:0]            op_cnt_q;   // Words left in this receive operation
    logic [`DMA_FLIT_W-1:0] pkt_cnt_q;  // Payload flits left in the packet

    logic rx_start;
    logic accept;

    assign rx_start = start_i && (operation_i == DMA_OP_RECEIVE);
    assign accept   = (state_q == RX_DATA) && noc_rx_i && mem.gnt;

    always_comb begin
        state_d = state_q;
        case (state_q)
            RX_HEADER: begin
                if (noc_rx_i)
                    state_d = RX_SIZE;
            end
            RX_SIZE: begin
                if (noc_rx_i)
                    state_d = (noc_data_i == '0) ? RX_HEADER : RX_WAIT;  // Empty packet
            end
            RX_WAIT: begin
                if (rx_start)
                    state_d = RX_DATA;
            end
            RX_DATA: begin
                if (accept) begin
                    if (pkt_cnt_q == `DMA_FLIT_W'(1))
                        state_d = RX_HEADER;
                    else if (op_cnt_q == 32'd1)
                        state_d = RX_WAIT;  // Rest of the packet waits for software
                end
            end
            default: state_d = RX_HEADER;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni)
            state_q <= RX_HEADER;
        else
            state_q <= state_d;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            addr_q   <= '0;
            op_cnt_q <= '0;
        end else if (state_q == RX_WAIT && rx_start) begin
            addr_q   <= address_i;
            op_cnt_q <= size_i;
        end else if (accept) begin
            addr_q   <= addr_q + 32'(`DMA_ADDR_STEP);
            op_cnt_q <= op_cnt_q - 32'd1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni)
            pkt_cnt_q <= '0;
        else if (state_q == RX_SIZE && noc_rx_i)
            pkt_cnt_q <= noc_data_i;
        else if (accept)
            pkt_cnt_q <= pkt_cnt_q - `DMA_FLIT_W'(1);
    end

    // Flow control toward the router
    always_comb begin
        case (state_q)
            RX_WAIT: noc_credit_o = 1'b0;
            RX_DATA: noc_credit_o = noc_rx_i && mem.gnt;
            default: noc_credit_o = 1'b1;
        endcase
    end

    assign mem.req   = (state_q == RX_DATA);
    assign mem.we    = (state_q == RX_DATA) && noc_rx_i;  // Write only with a flit present
    assign mem.addr  = addr_q;
    assign mem.wdata = noc_data_i;

    assign active_o          = (state_q == RX_DATA);
    assign available_o       = (state_q == RX_WAIT);
    assign flits_available_o = pkt_cnt_q;

endmodule

`default_nettype wire

// ==== common/mem_port_if.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dma_config.svh"

interface mem_port_if;

    logic                     req;    // Engine is in its data phase
    logic                     gnt;
    logic [31:0]              addr;
    logic                     we;     // High for a write
    logic [`DMA_FLIT_W-1:0]   wdata;

    modport engine (
        output req,
        output addr,
        output we,
        output wdata,
        input  gnt
    );

    modport arbiter (
        input  req,
        input  addr,
        input  we,
        input  wdata,
        output gnt
    );

endinterface

`default_nettype wire

// ==== common/dma_pkg.sv ====
`default_nettype none

package dma_pkg;

    // Operation launched by a start strobe
    typedef enum logic {
        DMA_OP_SEND    = 1'b0,
        DMA_OP_RECEIVE = 1'b1
    } dma_op_t;

    // Memory port owner
    typedef enum logic {
        SRC_SEND    = 1'b0,
        SRC_RECEIVE = 1'b1
    } dma_src_t;

endpackage

`default_nettype wire

// ==== common/dma_config.svh ====
`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

// Hermes flit width, also the memory data width
`define DMA_FLIT_W 32

// Byte address step between consecutive words
`define DMA_ADDR_STEP 4

// Cycles a grant is held while the other engine waits
`define DMA_SLICE_CYCLES 15

`endif
